/* verilog/i2c_axil_pkg.sv */
// shared widths, vector types, link structs and FSM encodings for the I2C to AXI4-Lite bridge
package i2c_axil_pkg;

    // bus geometry, fixed for this subsystem
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int REG_WORDS = 16;

    // clk samples a line must hold before a new level is taken
    localparam int FILTER_LEN = 4;

    typedef logic [ADDR_W-1:0] axil_addr_t;
    typedef logic [DATA_W-1:0] axil_data_t;
    typedef logic [STRB_W-1:0] axil_strb_t;
    typedef logic [7:0] i2c_byte_t;
    typedef logic [6:0] dev_addr_t;

    // received byte, last marks the final byte before stop or repeated start
    typedef struct packed {
        i2c_byte_t data;
        logic      last;
    } i2c_rx_t;

    // aw and w payload, issued together by the bridge
    typedef struct packed {
        axil_addr_t addr;
        axil_data_t data;
        axil_strb_t strb;
    } axil_wr_req_t;

    typedef enum logic [2:0] {
        I2C_IDLE,
        I2C_ADDR,
        I2C_ACK,
        I2C_WRITE,
        I2C_READ,
        I2C_READ_ACK
    } i2c_state_t;

    typedef enum logic [2:0] {
        BR_IDLE,
        BR_ADDR,
        BR_READ_WAIT,
        BR_READ_SEND,
        BR_WR_COLLECT,
        BR_WR_WAIT
    } bridge_state_t;

endpackage

/* verilog/i2c_target.sv */
// byte-level I2C target: filters the pins, matches the device address, acks and stretches SCL
`timescale 1ns/1ps
module i2c_target (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    scl_i,
    input  logic                    sda_i,
    output logic                    scl_o,
    output logic                    sda_o,
    input  logic                    enable_i,
    input  i2c_axil_pkg::dev_addr_t device_address_i,
    output i2c_axil_pkg::i2c_rx_t   rx_o,
    output logic                    rx_valid_o,
    input  logic                    rx_ready_i,
    input  i2c_axil_pkg::i2c_byte_t tx_data_i,
    input  logic                    tx_valid_i,
    output logic                    tx_ready_o,
    output logic                    bus_active_o,
    output logic                    bus_addressed_o
);

    // index 0 is scl, index 1 is sda
    logic [1:0][i2c_axil_pkg::FILTER_LEN-1:0] hist;
    logic [1:0] line_q;
    logic [1:0] line_d;
    logic       scl;
    logic       sda;
    logic       scl_rise;
    logic       scl_fall;
    logic       start_det;
    logic       stop_det;

    i2c_axil_pkg::i2c_state_t state;
    i2c_axil_pkg::i2c_byte_t  shift;
    logic [3:0]               bit_cnt;
    // set for a read addressing
    logic                     rw;
    logic                     stretch;
    // byte held back until we know if another one follows
    i2c_axil_pkg::i2c_byte_t  pend;
    logic                     pend_valid;
    i2c_axil_pkg::i2c_byte_t  tx_buf;
    logic                     tx_full;

    // glitch filter, level only moves once all samples agree
    always_ff @(posedge clk) begin
        if (rst) begin
            hist <= '1;
            line_q <= 2'b11;
            line_d <= 2'b11;
        end else begin
            hist[0] <= {hist[0][i2c_axil_pkg::FILTER_LEN-2:0], scl_i};
            hist[1] <= {hist[1][i2c_axil_pkg::FILTER_LEN-2:0], sda_i};
            line_d <= line_q;
            for (int i = 0; i < 2; i++) begin
                if (&hist[i]) begin
                    line_q[i] <= 1'b1;
                end else if (~|hist[i]) begin
                    line_q[i] <= 1'b0;
                end
            end
        end
    end

    assign scl = line_q[0];
    assign sda = line_q[1];
    assign scl_rise = scl && !line_d[0];
    assign scl_fall = !scl && line_d[0];
    // sda moving while scl stays high
    assign start_det = scl && line_d[0] && line_d[1] && !sda;
    assign stop_det = scl && line_d[0] && !line_d[1] && sda;

    // hold scl low while waiting on the bridge
    assign scl_o = !stretch;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= i2c_axil_pkg::I2C_IDLE;
            bit_cnt <= '0;
            rw <= 1'b0;
            stretch <= 1'b0;
            pend_valid <= 1'b0;
            tx_full <= 1'b0;
            tx_ready_o <= 1'b0;
            rx_valid_o <= 1'b0;
            sda_o <= 1'b1;
            bus_active_o <= 1'b0;
            bus_addressed_o <= 1'b0;
        end else begin
            if (rx_valid_o && rx_ready_i) begin
                rx_valid_o <= 1'b0;
            end
            // next read byte parked until its slot comes
            if (tx_ready_o && tx_valid_i) begin
                tx_buf <= tx_data_i;
                tx_full <= 1'b1;
                tx_ready_o <= 1'b0;
            end

            if (start_det || stop_det) begin
                // a held byte is the last of its transfer
                if (pend_valid) begin
                    rx_o <= '{data: pend, last: 1'b1};
                    rx_valid_o <= 1'b1;
                    pend_valid <= 1'b0;
                end
                state <= start_det ? i2c_axil_pkg::I2C_ADDR : i2c_axil_pkg::I2C_IDLE;
                bit_cnt <= '0;
                sda_o <= 1'b1;
                stretch <= 1'b0;
                tx_ready_o <= 1'b0;
                tx_full <= 1'b0;
                bus_active_o <= start_det;
                bus_addressed_o <= 1'b0;
            end else begin
                case (state)
                    i2c_axil_pkg::I2C_ADDR, i2c_axil_pkg::I2C_WRITE: begin
                        if (scl_rise) begin
                            shift <= {shift[6:0], sda};
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                        // first bit complete, so the held byte was not the last
                        if (scl_fall && bit_cnt == 4'd1 && pend_valid) begin
                            rx_o <= '{data: pend, last: 1'b0};
                            rx_valid_o <= 1'b1;
                            pend_valid <= 1'b0;
                        end
                        if (scl_fall && bit_cnt == 4'd8) begin
                            bit_cnt <= '0;
                            if (state == i2c_axil_pkg::I2C_WRITE) begin
                                // every written byte is acked
                                pend <= shift;
                                pend_valid <= 1'b1;
                                sda_o <= 1'b0;
                                state <= i2c_axil_pkg::I2C_ACK;
                            end else if (enable_i && shift[7:1] == device_address_i) begin
                                sda_o <= 1'b0;
                                rw <= shift[0];
                                tx_ready_o <= shift[0];
                                bus_addressed_o <= 1'b1;
                                state <= i2c_axil_pkg::I2C_ACK;
                            end else begin
                                // not us, wait for the next start
                                state <= i2c_axil_pkg::I2C_IDLE;
                            end
                        end
                    end
                    i2c_axil_pkg::I2C_ACK: begin
                        // end of ack slot, stretch until the bridge has caught up
                        if (scl_fall) begin
                            stretch <= 1'b1;
                        end
                        if (stretch && (rw ? tx_full : !rx_valid_o)) begin
                            stretch <= 1'b0;
                            tx_full <= 1'b0;
                            sda_o <= rw ? tx_buf[7] : 1'b1;
                            shift <= {tx_buf[6:0], 1'b0};
                            bit_cnt <= rw ? 4'd1 : 4'd0;
                            state <= rw ? i2c_axil_pkg::I2C_READ : i2c_axil_pkg::I2C_WRITE;
                        end
                    end
                    i2c_axil_pkg::I2C_READ: begin
                        if (scl_fall) begin
                            if (bit_cnt == 4'd8) begin
                                // release sda for the controller's ack
                                sda_o <= 1'b1;
                                state <= i2c_axil_pkg::I2C_READ_ACK;
                            end else begin
                                sda_o <= shift[7];
                                shift <= {shift[6:0], 1'b0};
                                bit_cnt <= bit_cnt + 4'd1;
                            end
                        end
                    end
                    i2c_axil_pkg::I2C_READ_ACK: begin
                        if (scl_rise) begin
                            if (!sda) begin
                                // ack, another byte wanted
                                tx_ready_o <= 1'b1;
                                state <= i2c_axil_pkg::I2C_ACK;
                            end else begin
                                state <= i2c_axil_pkg::I2C_IDLE;
                            end
                        end
                    end
                    default: begin
                        state <= i2c_axil_pkg::I2C_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* verilog/i2c_axil_bridge.sv */
// bridge FSM: turns the I2C byte stream into coalesced AXI4-Lite word reads and writes
`timescale 1ns/1ps
module i2c_axil_bridge (
    input  logic                       clk,
    input  logic                       rst,
    input  i2c_axil_pkg::i2c_rx_t      rx_i,
    input  logic                       rx_valid_i,
    output logic                       rx_ready_o,
    output i2c_axil_pkg::i2c_byte_t    tx_data_o,
    output logic                       tx_valid_o,
    input  logic                       tx_ready_i,
    input  logic                       bus_addressed_i,
    output i2c_axil_pkg::axil_wr_req_t wr_req_o,
    output logic                       awvalid_o,
    output logic                       wvalid_o,
    input  logic                       awready_i,
    input  logic                       wready_i,
    input  logic                       bvalid_i,
    output logic                       bready_o,
    output i2c_axil_pkg::axil_addr_t   araddr_o,
    output logic                       arvalid_o,
    input  logic                       arready_i,
    input  i2c_axil_pkg::axil_data_t   rdata_i,
    input  logic                       rvalid_i,
    output logic                       rready_o,
    output logic                       busy_o
);

    i2c_axil_pkg::bridge_state_t state;
    // byte pointer into the register space
    i2c_axil_pkg::axil_addr_t    ptr;
    i2c_axil_pkg::axil_addr_t    word_addr;
    i2c_axil_pkg::axil_addr_t    next_ptr;
    // current byte lane within the word
    logic [$clog2(i2c_axil_pkg::STRB_W)-1:0] lane;
    logic                        last_q;
    i2c_axil_pkg::axil_data_t    rd_word;

    assign word_addr = ptr & ~i2c_axil_pkg::axil_addr_t'(i2c_axil_pkg::STRB_W - 1);
    assign next_ptr = word_addr + i2c_axil_pkg::axil_addr_t'(i2c_axil_pkg::STRB_W);

    assign rx_ready_o = (state == i2c_axil_pkg::BR_ADDR) ||
                        (state == i2c_axil_pkg::BR_WR_COLLECT);
    assign bready_o = state == i2c_axil_pkg::BR_WR_WAIT;
    assign rready_o = state == i2c_axil_pkg::BR_READ_WAIT;
    assign araddr_o = word_addr;
    assign busy_o = state != i2c_axil_pkg::BR_IDLE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= i2c_axil_pkg::BR_IDLE;
            ptr <= '0;
            lane <= '0;
            last_q <= 1'b0;
            awvalid_o <= 1'b0;
            wvalid_o <= 1'b0;
            arvalid_o <= 1'b0;
            tx_valid_o <= 1'b0;
        end else begin
            // address channels drop independently on their ready
            if (awready_i) begin
                awvalid_o <= 1'b0;
            end
            if (wready_i) begin
                wvalid_o <= 1'b0;
            end
            if (arready_i) begin
                arvalid_o <= 1'b0;
            end

            case (state)
                i2c_axil_pkg::BR_IDLE: begin
                    // a byte means write, tx_ready means read
                    if (rx_valid_i) begin
                        state <= i2c_axil_pkg::BR_ADDR;
                    end else if (tx_ready_i) begin
                        arvalid_o <= 1'b1;
                        state <= i2c_axil_pkg::BR_READ_WAIT;
                    end
                end
                i2c_axil_pkg::BR_ADDR: begin
                    // first byte of a write sets the pointer
                    if (rx_valid_i) begin
                        ptr <= rx_i.data;
                        lane <= rx_i.data[$bits(lane)-1:0];
                        wr_req_o.data <= '0;
                        wr_req_o.strb <= '0;
                        if (rx_i.last) begin
                            state <= i2c_axil_pkg::BR_IDLE;
                        end else begin
                            state <= i2c_axil_pkg::BR_WR_COLLECT;
                        end
                    end
                end
                i2c_axil_pkg::BR_WR_COLLECT: begin
                    if (rx_valid_i) begin
                        wr_req_o.data[8*lane +: 8] <= rx_i.data;
                        wr_req_o.strb[lane] <= 1'b1;
                        lane <= lane + 1'b1;
                        last_q <= rx_i.last;
                        // full word or end of transfer, issue aw and w
                        if (&lane || rx_i.last) begin
                            wr_req_o.addr <= word_addr;
                            awvalid_o <= 1'b1;
                            wvalid_o <= 1'b1;
                            state <= i2c_axil_pkg::BR_WR_WAIT;
                        end
                    end
                end
                i2c_axil_pkg::BR_WR_WAIT: begin
                    if (bvalid_i) begin
                        ptr <= next_ptr;
                        // unwritten lanes go out as zero with no strobe
                        wr_req_o.data <= '0;
                        wr_req_o.strb <= '0;
                        if (last_q) begin
                            state <= i2c_axil_pkg::BR_IDLE;
                        end else begin
                            state <= i2c_axil_pkg::BR_WR_COLLECT;
                        end
                    end
                end
                i2c_axil_pkg::BR_READ_WAIT: begin
                    if (rvalid_i) begin
                        rd_word <= rdata_i;
                        lane <= ptr[$bits(lane)-1:0];
                        ptr <= next_ptr;
                        state <= i2c_axil_pkg::BR_READ_SEND;
                    end
                end
                i2c_axil_pkg::BR_READ_SEND: begin
                    // stop, repeated start or a write ends the read
                    if (rx_valid_i || !bus_addressed_i) begin
                        tx_valid_o <= 1'b0;
                        state <= i2c_axil_pkg::BR_IDLE;
                    end else if (tx_valid_o) begin
                        if (tx_ready_i) begin
                            tx_valid_o <= 1'b0;
                            lane <= lane + 1'b1;
                            // lane 3 sent, next word fetched on demand
                            if (&lane) begin
                                state <= i2c_axil_pkg::BR_IDLE;
                            end
                        end
                    end else begin
                        tx_data_o <= rd_word[8*lane +: 8];
                        tx_valid_o <= 1'b1;
                    end
                end
                default: begin
                    state <= i2c_axil_pkg::BR_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/axil_regfile.sv */
// AXI4-Lite target with 16 word registers and byte strobes, the bus end of the bridge
`timescale 1ns/1ps
module axil_regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  i2c_axil_pkg::axil_wr_req_t wr_req_i,
    input  logic                       awvalid_i,
    input  logic                       wvalid_i,
    output logic                       awready_o,
    output logic                       wready_o,
    output logic                       bvalid_o,
    input  logic                       bready_i,
    input  i2c_axil_pkg::axil_addr_t   araddr_i,
    input  logic                       arvalid_i,
    output logic                       arready_o,
    output i2c_axil_pkg::axil_data_t   rdata_o,
    output logic                       rvalid_o,
    input  logic                       rready_i
);

    i2c_axil_pkg::axil_data_t mem [i2c_axil_pkg::REG_WORDS];
    // word index from address bits 5..2, upper bits wrap
    logic [$clog2(i2c_axil_pkg::REG_WORDS)-1:0] wr_idx;
    logic [$clog2(i2c_axil_pkg::REG_WORDS)-1:0] rd_idx;
    logic                                       wr_accept;
    logic                                       rd_accept;

    assign wr_idx = wr_req_i.addr[$clog2(i2c_axil_pkg::STRB_W) +:
                                  $clog2(i2c_axil_pkg::REG_WORDS)];
    assign rd_idx = araddr_i[$clog2(i2c_axil_pkg::STRB_W) +:
                             $clog2(i2c_axil_pkg::REG_WORDS)];

    // aw and w only together, one access in flight per direction
    assign wr_accept = awvalid_i && wvalid_i && !awready_o && !bvalid_o;
    assign rd_accept = arvalid_i && !arready_o && !rvalid_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready_o <= 1'b0;
            wready_o <= 1'b0;
            bvalid_o <= 1'b0;
            arready_o <= 1'b0;
            rvalid_o <= 1'b0;
            for (int i = 0; i < i2c_axil_pkg::REG_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            awready_o <= wr_accept;
            wready_o <= wr_accept;
            // write lands during the ready pulse, response next cycle
            if (awready_o) begin
                for (int i = 0; i < i2c_axil_pkg::STRB_W; i++) begin
                    if (wr_req_i.strb[i]) begin
                        mem[wr_idx][8*i +: 8] <= wr_req_i.data[8*i +: 8];
                    end
                end
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end

            arready_o <= rd_accept;
            if (arready_o) begin
                rdata_o <= mem[rd_idx];
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

endmodule

/* verilog/i2c_axil_top.sv */
// top level of the I2C register access subsystem: target, bridge and register file
`timescale 1ns/1ps
module i2c_axil_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    scl_i,
    input  logic                    sda_i,
    output logic                    scl_o,
    output logic                    sda_o,
    input  logic                    enable_i,
    input  i2c_axil_pkg::dev_addr_t device_address_i,
    output logic                    busy_o,
    output logic                    bus_active_o,
    output logic                    bus_addressed_o
);

    // byte links between target and bridge
    i2c_axil_pkg::i2c_rx_t      rx;
    logic                       rx_valid;
    logic                       rx_ready;
    i2c_axil_pkg::i2c_byte_t    tx_data;
    logic                       tx_valid;
    logic                       tx_ready;

    // AXI4-Lite between bridge and register file
    i2c_axil_pkg::axil_wr_req_t wr_req;
    logic                       awvalid;
    logic                       wvalid;
    logic                       awready;
    logic                       wready;
    logic                       bvalid;
    logic                       bready;
    i2c_axil_pkg::axil_addr_t   araddr;
    logic                       arvalid;
    logic                       arready;
    i2c_axil_pkg::axil_data_t   rdata;
    logic                       rvalid;
    logic                       rready;

    i2c_target i_i2c_target (
        .clk              (clk),
        .rst              (rst),
        .scl_i            (scl_i),
        .sda_i            (sda_i),
        .scl_o            (scl_o),
        .sda_o            (sda_o),
        .enable_i         (enable_i),
        .device_address_i (device_address_i),
        .rx_o             (rx),
        .rx_valid_o       (rx_valid),
        .rx_ready_i       (rx_ready),
        .tx_data_i        (tx_data),
        .tx_valid_i       (tx_valid),
        .tx_ready_o       (tx_ready),
        .bus_active_o     (bus_active_o),
        .bus_addressed_o  (bus_addressed_o)
    );

    i2c_axil_bridge i_i2c_axil_bridge (
        .clk             (clk),
        .rst             (rst),
        .rx_i            (rx),
        .rx_valid_i      (rx_valid),
        .rx_ready_o      (rx_ready),
        .tx_data_o       (tx_data),
        .tx_valid_o      (tx_valid),
        .tx_ready_i      (tx_ready),
        .bus_addressed_i (bus_addressed_o),
        .wr_req_o        (wr_req),
        .awvalid_o       (awvalid),
        .wvalid_o        (wvalid),
        .awready_i       (awready),
        .wready_i        (wready),
        .bvalid_i        (bvalid),
        .bready_o        (bready),
        .araddr_o        (araddr),
        .arvalid_o       (arvalid),
        .arready_i       (arready),
        .rdata_i         (rdata),
        .rvalid_i        (rvalid),
        .rready_o        (rready),
        .busy_o          (busy_o)
    );

    axil_regfile i_axil_regfile (
        .clk       (clk),
        .rst       (rst),
        .wr_req_i  (wr_req),
        .awvalid_i (awvalid),
        .wvalid_i  (wvalid),
        .awready_o (awready),
        .wready_o  (wready),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

endmodule

/* sim/tb_clock.sv */
// testbench clock source, instantiated by the testbench to drive clk with a 4 ns period
`timescale 1ns/1ps
module tb_clock (
    output logic clk_o
);

    localparam int HALF_NS = 2;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_NS) clk_o = ~clk_o;
        end
    end

endmodule

/* sim/i2c_axil_tb.sv */
// testbench for i2c_axil_top: I2C controller model, reference byte memory and checks
`timescale 1ns/1ps
module i2c_axil_tb;

    // scl half period in clk cycles, data moves a quarter period into the low phase
    localparam int HALF = 20;
    localparam int QUARTER = HALF / 2;
    localparam int MEM_BYTES = i2c_axil_pkg::REG_WORDS * i2c_axil_pkg::STRB_W;
    localparam int MEM_AW = $clog2(MEM_BYTES);
    // about 90 bytes at 360 cycles each, plus start and stop framing
    localparam int MAX_CYCLES = 40000;
    localparam i2c_axil_pkg::dev_addr_t DEV_ADDR = 7'h42;
    localparam i2c_axil_pkg::dev_addr_t WRONG_ADDR = 7'h13;

    logic clk;
    logic rst;
    logic enable;
    i2c_axil_pkg::dev_addr_t dev_addr;
    // controller side of the open-drain lines
    logic scl_m;
    logic sda_m;
    logic scl_line;
    logic sda_line;
    logic dut_scl;
    logic dut_sda;
    logic busy;
    logic bus_active;
    logic bus_addressed;

    i2c_axil_pkg::i2c_byte_t ref_mem [MEM_BYTES];
    logic [31:0] rng_state = 32'ha68a;
    int mismatch_errs = 0;
    int other_errs = 0;
    int cycle_cnt = 0;

    tb_clock i_tb_clock (
        .clk_o (clk)
    );

    // wired AND of controller and target
    assign scl_line = scl_m & dut_scl;
    assign sda_line = sda_m & dut_sda;

    i2c_axil_top i_i2c_axil_top (
        .clk              (clk),
        .rst              (rst),
        .scl_i            (scl_line),
        .sda_i            (sda_line),
        .scl_o            (dut_scl),
        .sda_o            (dut_sda),
        .enable_i         (enable),
        .device_address_i (dev_addr),
        .busy_o           (busy),
        .bus_active_o     (bus_active),
        .bus_addressed_o  (bus_addressed)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the I2C transfers did not finish", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic i2c_axil_pkg::i2c_byte_t next_rand_byte();
        rng_state = lcg_step(rng_state);
        return rng_state[23:16];
    endfunction

    // byte address in the model, wraps modulo 64
    function automatic logic [MEM_AW-1:0] mem_index(input i2c_axil_pkg::i2c_byte_t ptr,
                                                   input int offset);
        return MEM_AW'(int'(ptr) + offset);
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_byte(input string name, input i2c_axil_pkg::i2c_byte_t exp,
                              input i2c_axil_pkg::i2c_byte_t got);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s expected 0x%02h actual 0x%02h", $time, name, exp, got);
            mismatch_errs++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, got);
            mismatch_errs++;
        end
    endtask

    // let scl go high, the target may still hold it low
    task automatic release_scl();
        scl_m = 1'b1;
        while (!scl_line) begin
            step(1);
        end
    endtask

    task automatic send_bit(input logic b);
        step(QUARTER);
        sda_m = b;
        step(QUARTER);
        release_scl();
        step(HALF);
        scl_m = 1'b0;
    endtask

    task automatic recv_bit(output logic b);
        step(QUARTER);
        sda_m = 1'b1;
        step(QUARTER);
        release_scl();
        step(QUARTER);
        b = sda_line;
        step(QUARTER);
        scl_m = 1'b0;
    endtask

    task automatic send_start();
        if (!scl_m) begin
            // repeated start, sda up while scl is still low
            step(QUARTER);
            sda_m = 1'b1;
            step(QUARTER);
            release_scl();
        end
        step(HALF);
        sda_m = 1'b0;
        step(HALF);
        scl_m = 1'b0;
    endtask

    task automatic send_stop();
        step(QUARTER);
        sda_m = 1'b0;
        step(QUARTER);
        release_scl();
        step(HALF);
        sda_m = 1'b1;
        step(HALF);
    endtask

    task automatic send_byte(input i2c_axil_pkg::i2c_byte_t data, output logic acked);
        i2c_axil_pkg::i2c_byte_t sh;
        logic nack;
        sh = data;
        // msb first
        repeat (8) begin
            send_bit(sh[7]);
            sh = sh << 1;
        end
        recv_bit(nack);
        acked = !nack;
    endtask

    task automatic recv_byte(input logic ack, output i2c_axil_pkg::i2c_byte_t data);
        logic b;
        data = '0;
        repeat (8) begin
            recv_bit(b);
            data = {data[6:0], b};
        end
        send_bit(!ack);
    endtask

    task automatic send_expect_ack(input i2c_axil_pkg::i2c_byte_t data, input string what);
        logic acked;
        send_byte(data, acked);
        assert (acked) else begin
            $display("No acknowledge for the %s byte 0x%02h at %0t", what, data, $time);
            other_errs++;
        end
    endtask

    task automatic wait_idle();
        while (busy) begin
            step(1);
        end
    endtask

    // pointer then n random bytes, model updated per byte
    task automatic write_random(input i2c_axil_pkg::i2c_byte_t ptr, input int n);
        i2c_axil_pkg::i2c_byte_t d;
        send_start();
        send_expect_ack({DEV_ADDR, 1'b0}, "write address");
        send_expect_ack(ptr, "pointer");
        for (int i = 0; i < n; i++) begin
            d = next_rand_byte();
            send_expect_ack(d, "data");
            ref_mem[mem_index(ptr, i)] = d;
        end
        send_stop();
        wait_idle();
    endtask

    task automatic read_check(input i2c_axil_pkg::i2c_byte_t ptr, input int n,
                              input logic rep_start);
        i2c_axil_pkg::i2c_byte_t got;
        logic [MEM_AW-1:0] idx;
        send_start();
        send_expect_ack({DEV_ADDR, 1'b0}, "write address");
        send_expect_ack(ptr, "pointer");
        if (!rep_start) begin
            send_stop();
            wait_idle();
        end
        send_start();
        send_expect_ack({DEV_ADDR, 1'b1}, "read address");
        for (int i = 0; i < n; i++) begin
            // nack on the final byte
            recv_byte(i < n - 1, got);
            idx = mem_index(ptr, i);
            check_byte($sformatf("read byte 0x%02h", idx), ref_mem[idx], got);
        end
        check_level("bus_active_o", 1'b1, bus_active);
        check_level("bus_addressed_o", 1'b1, bus_addressed);
        send_stop();
        wait_idle();
    endtask

    initial begin
        logic acked;
        rst = 1'b1;
        enable = 1'b1;
        dev_addr = DEV_ADDR;
        scl_m = 1'b1;
        sda_m = 1'b1;
        ref_mem = '{default: '0};
        step(10);
        rst = 1'b0;
        step(2);

        // idle levels out of reset
        check_level("scl_o", 1'b1, dut_scl);
        check_level("sda_o", 1'b1, dut_sda);
        check_level("busy_o", 1'b0, busy);
        check_level("bus_active_o", 1'b0, bus_active);
        check_level("bus_addressed_o", 1'b0, bus_addressed);

        // one aligned word
        write_random(8'h00, 4);
        read_check(8'h00, 4, 1'b0);

        // lower half first, then upper half with strobes only on lanes 2 and 3
        write_random(8'h04, 2);
        write_random(8'h06, 2);
        read_check(8'h04, 8, 1'b0);

        // multi word write and reads across word boundaries
        write_random(8'h10, 10);
        read_check(8'h10, 12, 1'b0);
        read_check(8'h11, 5, 1'b0);

        // foreign address, following bytes must be ignored
        send_start();
        send_byte({WRONG_ADDR, 1'b0}, acked);
        assert (!acked) else begin
            $display("Target acknowledged the foreign address 0x%02h at %0t", WRONG_ADDR, $time);
            other_errs++;
        end
        check_level("bus_addressed_o", 1'b0, bus_addressed);
        check_level("bus_active_o", 1'b1, bus_active);
        send_byte(8'h04, acked);
        send_byte(~ref_mem[4], acked);
        check_level("bus_addressed_o", 1'b0, bus_addressed);
        send_stop();
        read_check(8'h04, 4, 1'b0);

        // pointer write, then repeated start into the read
        write_random(8'h20, 2);
        read_check(8'h20, 6, 1'b1);
        check_level("bus_active_o", 1'b0, bus_active);

        $display("Checks done: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/i2c_axil_pkg.sv
verilog/i2c_target.sv
verilog/i2c_axil_bridge.sv
verilog/axil_regfile.sv
verilog/i2c_axil_top.sv
sim/tb_clock.sv
sim/i2c_axil_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the I2C to AXI4-Lite testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module i2c_axil_tb -f filelist.f -o i2c_axil_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/i2c_axil_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
